/* src/rv_core_pkg.sv */
// ******************************
// rv core shared types, opcodes
// and ALU operation encoding
// ******************************
package rv_core_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes kept by the integer core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // LUI result is the immediate itself
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // control travelling with one instruction
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      we;
    } ctrl_t;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

/* src/int_alu.sv */
// ******************************
// combinational integer ALU
// ******************************
`timescale 1ns/1ps

module int_alu #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0]     a_i,
    input  logic [XLEN-1:0]     b_i,
    input  rv_core_pkg::alu_op_e alu_op_i,
    output logic [XLEN-1:0]     result_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;

    // only the low bits count as shift amount
    assign shamt = b_i[SHW-1:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_core_pkg::ALU_SLT:    result_o = XLEN'(lt_s);
            rv_core_pkg::ALU_SLTU:   result_o = XLEN'(lt_u);
            rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_core_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_core_pkg::ALU_PASS_B: result_o = b_i;
            default:                 result_o = '0;
        endcase
    end

endmodule

/* src/regfile.sv */
// ******************************
// integer register file with x0 held at zero
// ******************************
`timescale 1ns/1ps

module regfile #(
    parameter int XLEN = 64
) (
    input  logic                   c_clk,
    input  logic                   c_rst_n,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    output logic [XLEN-1:0]        rs1_data_o,
    output logic [XLEN-1:0]        rs2_data_o,
    input  logic                   wr_en_i,
    input  rv_core_pkg::reg_addr_t wr_addr_i,
    input  logic [XLEN-1:0]        wr_data_i
);

    logic [XLEN-1:0] regs [1:31];

    // same-cycle write is visible to the reader
    function automatic logic [XLEN-1:0] rd_port(input rv_core_pkg::reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = rd_port(rs1_addr_i);
        rs2_data_o = rd_port(rs2_addr_i);
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != 5'd0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

/* src/decode_stage.sv */
// ******************************
// decode stage, immediate format
// and decode-to-execute register
// ******************************
`timescale 1ns/1ps

module decode_stage #(
    parameter int XLEN = 64
) (
    input  logic                   c_clk,
    input  logic                   c_rst_n,
    input  logic                   in_valid_i,
    input  rv_core_pkg::instr_t    instr_i,
    output rv_core_pkg::reg_addr_t rs1_addr_o,
    output rv_core_pkg::reg_addr_t rs2_addr_o,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,
    output rv_core_pkg::ctrl_t     ctrl_o,
    output logic [XLEN-1:0]        op_a_o,
    output logic [XLEN-1:0]        op_b_o,
    output logic [XLEN-1:0]        imm_o
);

    // control of addi x0, x0, 0 held while in reset
    localparam rv_core_pkg::ctrl_t NOP_CTRL = '{
        valid:   1'b0,
        rd:      rv_core_pkg::NOP_INSTR[11:7],
        rs1:     rv_core_pkg::NOP_INSTR[19:15],
        rs2:     rv_core_pkg::NOP_INSTR[24:20],
        alu_op:  rv_core_pkg::ALU_ADD,
        use_imm: 1'b1,
        we:      1'b0
    };

    logic [2:0]           funct3;
    logic                 alt;
    rv_core_pkg::ctrl_t   dec_ctrl;
    logic [XLEN-1:0]      dec_imm;

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign funct3     = instr_i[14:12];
    // funct7 bit 5 picks sub and arithmetic shift
    assign alt        = instr_i[30];

    always_comb begin
        dec_ctrl.valid   = 1'b0;
        dec_ctrl.rd      = instr_i[11:7];
        dec_ctrl.rs1     = instr_i[19:15];
        dec_ctrl.rs2     = instr_i[24:20];
        dec_ctrl.alu_op  = rv_core_pkg::ALU_ADD;
        dec_ctrl.use_imm = 1'b1;
        dec_imm          = XLEN'($signed(instr_i[31:20]));
        case (instr_i[6:0])
            rv_core_pkg::OPC_OP_IMM, rv_core_pkg::OPC_OP: begin
                dec_ctrl.valid   = in_valid_i;
                dec_ctrl.use_imm = (instr_i[6:0] == rv_core_pkg::OPC_OP_IMM);
                case (funct3)
                    3'b000: dec_ctrl.alu_op = (alt && !dec_ctrl.use_imm) ?
                                              rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b001: dec_ctrl.alu_op = rv_core_pkg::ALU_SLL;
                    3'b010: dec_ctrl.alu_op = rv_core_pkg::ALU_SLT;
                    3'b011: dec_ctrl.alu_op = rv_core_pkg::ALU_SLTU;
                    3'b100: dec_ctrl.alu_op = rv_core_pkg::ALU_XOR;
                    3'b101: dec_ctrl.alu_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                    3'b110: dec_ctrl.alu_op = rv_core_pkg::ALU_OR;
                    default: dec_ctrl.alu_op = rv_core_pkg::ALU_AND;
                endcase
            end
            rv_core_pkg::OPC_LUI: begin
                dec_ctrl.valid  = in_valid_i;
                dec_ctrl.alu_op = rv_core_pkg::ALU_PASS_B;
                dec_imm         = XLEN'($signed({instr_i[31:12], 12'b0}));
            end
            // anything else leaves a bubble
            default: dec_ctrl.valid = 1'b0;
        endcase
        dec_ctrl.we = (dec_ctrl.rd != 5'd0);
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            ctrl_o <= NOP_CTRL;
        end else begin
            ctrl_o <= dec_ctrl;
        end
    end

    always_ff @(posedge c_clk) begin
        op_a_o <= rs1_data_i;
        op_b_o <= rs2_data_i;
        imm_o  <= dec_imm;
    end

endmodule

/* src/exec_stage.sv */
// ******************************
// execute stage with forwarding
// and retire / write-back port
// ******************************
`timescale 1ns/1ps

module exec_stage #(
    parameter int XLEN = 64
) (
    input  logic                   c_clk,
    input  logic                   c_rst_n,
    input  rv_core_pkg::ctrl_t     ctrl_i,
    input  logic [XLEN-1:0]        op_a_i,
    input  logic [XLEN-1:0]        op_b_i,
    input  logic [XLEN-1:0]        imm_i,
    output logic                   wr_en_o,
    output rv_core_pkg::reg_addr_t wr_addr_o,
    output logic [XLEN-1:0]        wr_data_o,
    output logic                   retire_valid_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output logic [XLEN-1:0]        retire_data_o
);

    rv_core_pkg::ctrl_t     ex_ctrl;
    logic [XLEN-1:0]        ex_data;
    logic                   hist_vld;
    rv_core_pkg::reg_addr_t hist_rd;
    logic [XLEN-1:0]        hist_data;

    logic [XLEN-1:0]        alu_a;
    logic [XLEN-1:0]        fwd_b;
    logic [XLEN-1:0]        alu_b;
    logic [XLEN-1:0]        alu_res;

    // newest producer wins over the regfile value
    function automatic logic [XLEN-1:0] fwd_sel(input rv_core_pkg::reg_addr_t src,
                                                input logic [XLEN-1:0] dec_val);
        if (ex_ctrl.valid && ex_ctrl.we && ex_ctrl.rd == src) begin
            return ex_data;
        end else if (hist_vld && hist_rd == src) begin
            return hist_data;
        end
        return dec_val;
    endfunction

    always_comb begin
        alu_a = fwd_sel(ctrl_i.rs1, op_a_i);
        fwd_b = fwd_sel(ctrl_i.rs2, op_b_i);
        alu_b = ctrl_i.use_imm ? imm_i : fwd_b;
    end

    int_alu #(.XLEN(XLEN)) u_int_alu (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .alu_op_i (ctrl_i.alu_op),
        .result_o (alu_res)
    );

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            ex_ctrl  <= '0;
            hist_vld <= 1'b0;
            hist_rd  <= '0;
        end else begin
            ex_ctrl <= ctrl_i;
            // history keeps the last retired register write
            if (ex_ctrl.valid && ex_ctrl.we) begin
                hist_vld <= 1'b1;
                hist_rd  <= ex_ctrl.rd;
            end
        end
    end

    always_ff @(posedge c_clk) begin
        ex_data <= alu_res;
        if (ex_ctrl.valid && ex_ctrl.we) begin
            hist_data <= ex_data;
        end
    end

    assign wr_en_o        = ex_ctrl.valid && ex_ctrl.we;
    assign wr_addr_o      = ex_ctrl.rd;
    assign wr_data_o      = ex_data;
    assign retire_valid_o = ex_ctrl.valid;
    assign retire_rd_o    = ex_ctrl.rd;
    assign retire_data_o  = ex_data;

endmodule

/* src/rv_core_top.sv */
// ******************************
// integer core top level
// decode, register file, execute
// ******************************
`timescale 1ns/1ps

module rv_core_top #(
    parameter int XLEN = 64
) (
    input  logic                   c_clk,
    input  logic                   c_rst_n,
    input  logic                   in_valid_i,
    input  rv_core_pkg::instr_t    instr_i,
    output logic                   retire_valid_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output logic [XLEN-1:0]        retire_data_o
);

    rv_core_pkg::reg_addr_t rs1_addr;
    rv_core_pkg::reg_addr_t rs2_addr;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;

    rv_core_pkg::ctrl_t     dx_ctrl;
    logic [XLEN-1:0]        dx_op_a;
    logic [XLEN-1:0]        dx_op_b;
    logic [XLEN-1:0]        dx_imm;

    logic                   wr_en;
    rv_core_pkg::reg_addr_t wr_addr;
    logic [XLEN-1:0]        wr_data;

    decode_stage #(.XLEN(XLEN)) u_decode_stage (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .in_valid_i (in_valid_i),
        .instr_i    (instr_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ctrl_o     (dx_ctrl),
        .op_a_o     (dx_op_a),
        .op_b_o     (dx_op_b),
        .imm_o      (dx_imm)
    );

    // register file sits beside the execute stage it feeds
    regfile #(.XLEN(XLEN)) u_regfile (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data)
    );

    exec_stage #(.XLEN(XLEN)) u_exec_stage (
        .c_clk          (c_clk),
        .c_rst_n        (c_rst_n),
        .ctrl_i         (dx_ctrl),
        .op_a_i         (dx_op_a),
        .op_b_i         (dx_op_b),
        .imm_i          (dx_imm),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

/* verification/tb_rv_core.sv */
// ******************************
// testbench for the integer core
// random stream against a model
// ******************************
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          XLEN       = 64;
    localparam int          IDLE_SLOTS = 6;
    localparam int          RAND_SLOTS = 300;
    localparam int          TIMEOUT    = (IDLE_SLOTS + RAND_SLOTS + 20) * 2;
    localparam time         DRIVE_DLY  = 10ns;
    localparam logic [6:0]  OPC_IMM    = 7'h13;
    localparam logic [6:0]  OPC_REG    = 7'h33;
    localparam logic [6:0]  OPC_LUI    = 7'h37;

    // expected result of one outstanding instruction
    typedef struct packed {
        logic [31:0] idx;
        logic [31:0] cycle;
        logic [4:0]  rd;
        logic [63:0] data;
    } exp_entry_t;

    logic                   c_clk;
    logic                   c_rst_n;
    logic                   in_valid;
    rv_core_pkg::instr_t    instr;
    logic                   retire_valid;
    rv_core_pkg::reg_addr_t retire_rd;
    logic [XLEN-1:0]        retire_data;

    logic [31:0]     rng_state = 32'h6d17;
    logic [63:0]     rf_model [32];
    exp_entry_t      exp_q [$];
    int              cycle_cnt = 0;
    int              errors = 0;
    int              n_issued = 0;
    int              n_retired = 0;
    int              n_bubble = 0;
    int              n_gap = 0;

    rv_core_top #(.XLEN(XLEN)) u_rv_core_top (
        .c_clk          (c_clk),
        .c_rst_n        (c_rst_n),
        .in_valid_i     (in_valid),
        .instr_i        (instr),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    initial begin
        c_clk = 1'b0;
        forever #50 c_clk = ~c_clk;
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic is_supported(input logic [31:0] ins);
        return ins[6:0] == OPC_IMM || ins[6:0] == OPC_REG || ins[6:0] == OPC_LUI;
    endfunction

    // registers limited to x0..x7 so that dependencies are frequent
    function automatic logic [31:0] make_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [6:0]  opc;
        r1  = rand_next();
        r2  = rand_next();
        rd  = {2'b00, r1[31:29]};
        f3  = r1[22:20];
        imm = r2[31:20];
        f7  = (r1[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        case (r1[19:17])
            3'd0, 3'd1, 3'd2: begin
                // shifts carry a 6-bit shamt under funct6
                if (f3 == 3'b001) begin
                    imm = {6'b0, r2[25:20]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, r1[16], 4'b0, r2[25:20]};
                end
                return {imm, 2'b00, r1[28:26], f3, rd, OPC_IMM};
            end
            3'd3, 3'd4, 3'd5: return {f7, 2'b00, r1[25:23], 2'b00, r1[28:26], f3, rd, OPC_REG};
            3'd6: return {r2[31:12], rd, OPC_LUI};
            default: begin
                opc = r2[22:16];
                if (is_supported({25'b0, opc})) begin
                    opc = 7'h03;
                end
                return {r2[31:7], opc};
            end
        endcase
    endfunction

    // RV64I result from the architectural state at issue
    function automatic logic [63:0] model_result(input logic [31:0] ins);
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        a = rf_model[ins[19:15]];
        b = rf_model[ins[24:20]];
        if (ins[6:0] == OPC_LUI) begin
            return {{32{ins[31]}}, ins[31:12], 12'h000};
        end
        if (ins[6:0] == OPC_IMM) begin
            b = {{52{ins[31]}}, ins[31:20]};
        end
        sh = b[5:0];
        case (ins[14:12])
            3'b000: return (ins[6:0] == OPC_REG && ins[30]) ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011: return (a < b) ? 64'd1 : 64'd0;
            3'b100: return a ^ b;
            3'b101: return ins[30] ? 64'($signed(a) >>> sh) : a >> sh;
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // drive one issue slot, then move on to the next cycle
    task automatic issue_slot(input logic valid, input logic [31:0] ins);
        exp_entry_t e;
        in_valid = valid;
        instr    = ins;
        if (!valid) begin
            n_gap++;
        end else if (!is_supported(ins)) begin
            n_bubble++;
        end else begin
            e.idx   = n_issued;
            e.cycle = cycle_cnt + 2;
            e.rd    = ins[11:7];
            e.data  = model_result(ins);
            exp_q.push_back(e);
            if (ins[11:7] != 5'd0) begin
                rf_model[ins[11:7]] = e.data;
            end
            n_issued++;
        end
        @(posedge c_clk);
        #DRIVE_DLY;
    endtask

    // each retire against the oldest expected result
    always @(negedge c_clk) begin
        exp_entry_t e;
        if (c_rst_n === 1'b1) begin
            if (retire_valid === 1'b1) begin
                n_retired++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected retire of x%0d at cycle %0d", retire_rd, cycle_cnt);
                end else begin
                    e = exp_q.pop_front();
                    compare_value($sformatf("insn %0d rd", e.idx), e.rd, retire_rd);
                    compare_value($sformatf("insn %0d data", e.idx), e.data, retire_data);
                    compare_value($sformatf("insn %0d cycle", e.idx), e.cycle, cycle_cnt);
                end
            end else if (retire_valid !== 1'b0) begin
                errors++;
                $display("retire valid is unknown at cycle %0d", cycle_cnt);
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT) begin
            @(posedge c_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d results outstanding", cycle_cnt,
                 exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        c_rst_n  = 1'b0;
        in_valid = 1'b0;
        instr    = 32'h0000_0013;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        repeat (2) @(posedge c_clk);
        #DRIVE_DLY;
        c_rst_n = 1'b1;
        // quiet period without strobes
        repeat (IDLE_SLOTS) issue_slot(1'b0, 32'h0000_0013);
        for (int i = 0; i < RAND_SLOTS; i++) begin
            r = rand_next();
            issue_slot(r[31:29] != 3'd0, make_instr());
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge c_clk);
        end
        repeat (4) @(posedge c_clk);
        compare_value("retire count", n_issued, n_retired);
        $display("issued %0d retired %0d bubbles %0d gaps %0d errors %0d",
                 n_issued, n_retired, n_bubble, n_gap, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/rv_core_pkg.sv
src/int_alu.sv
src/regfile.sv
src/decode_stage.sv
src/exec_stage.sv
src/rv_core_top.sv
verification/tb_rv_core.sv
